/* logic/mem_axi_bridge_config.svh */
`ifndef MEM_AXI_BRIDGE_CONFIG_SVH
`define MEM_AXI_BRIDGE_CONFIG_SVH

// bus widths, one word per transfer
`define MAB_ADDR_W 32
`define MAB_DATA_W 32

// one strobe per data byte
`define MAB_STRB_W (`MAB_DATA_W / 8)

// axi transaction ids
`define MAB_ID_W 4

// fixed id per requester
`define MAB_FETCH_ID 0
`define MAB_DATA_ID  1

`endif

/* logic/mem_axi_pkg.sv */
`include "mem_axi_bridge_config.svh"

package mem_axi_pkg;

  // single beat per transaction
  localparam logic [7:0] AXI_LEN_SINGLE = 8'd0;

  // size field covers one full data word
  localparam logic [2:0] AXI_SIZE_WORD = 3'($clog2(`MAB_DATA_W / 8));

  localparam logic [1:0] AXI_BURST_INCR = 2'b01;

  // which requester holds the bus
  localparam logic [1:0] OWN_NONE  = 2'd0;
  localparam logic [1:0] OWN_FETCH = 2'd1;
  localparam logic [1:0] OWN_DATA  = 2'd2;

endpackage

/* logic/mem_axi_arbiter.sv */
`timescale 1ns/1ps
`include "mem_axi_bridge_config.svh"

module mem_axi_arbiter (
  input  logic                   clk,
  input  logic                   arst_n_i,
  // fetch port, read only
  input  logic                   fetch_req_i,
  input  logic [`MAB_ADDR_W-1:0] fetch_addr_i,
  output logic [`MAB_DATA_W-1:0] fetch_rdata_o,
  output logic                   fetch_done_o,
  // load/store port
  input  logic                   data_req_i,
  input  logic                   data_we_i,
  input  logic [`MAB_ADDR_W-1:0] data_addr_i,
  input  logic [`MAB_DATA_W-1:0] data_wdata_i,
  input  logic [`MAB_STRB_W-1:0] data_wstrb_i,
  output logic [`MAB_DATA_W-1:0] data_rdata_o,
  output logic                   data_done_o,
  // read master
  output logic                   rd_start_o,
  output logic [`MAB_ADDR_W-1:0] rd_addr_o,
  output logic [`MAB_ID_W-1:0]   rd_id_o,
  input  logic [`MAB_DATA_W-1:0] rd_data_i,
  input  logic                   rd_done_i,
  // write master
  output logic                   wr_start_o,
  output logic [`MAB_ADDR_W-1:0] wr_addr_o,
  output logic [`MAB_DATA_W-1:0] wr_data_o,
  output logic [`MAB_STRB_W-1:0] wr_strb_o,
  output logic [`MAB_ID_W-1:0]   wr_id_o,
  input  logic                   wr_done_i
);

  import mem_axi_pkg::*;

  logic [1:0]             owner_q;
  logic                   idle;
  logic                   grant_data;
  logic                   grant_fetch;
  logic                   finish;
  logic [`MAB_ADDR_W-1:0] addr_q;
  logic [`MAB_ID_W-1:0]   id_q;
  logic [`MAB_DATA_W-1:0] wdata_q;
  logic [`MAB_STRB_W-1:0] wstrb_q;

  // no grant while busy or while a done pulse is out
  assign idle        = (owner_q == OWN_NONE) && !fetch_done_o && !data_done_o;
  assign grant_data  = idle && data_req_i;                // data port wins
  assign grant_fetch = idle && fetch_req_i && !data_req_i;
  assign finish      = rd_done_i || wr_done_i;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      owner_q      <= OWN_NONE;
      rd_start_o   <= 1'b0;
      wr_start_o   <= 1'b0;
      fetch_done_o <= 1'b0;
      data_done_o  <= 1'b0;
    end else begin
      rd_start_o   <= grant_fetch || (grant_data && !data_we_i);
      wr_start_o   <= grant_data && data_we_i;
      fetch_done_o <= rd_done_i && (owner_q == OWN_FETCH);
      data_done_o  <= finish && (owner_q == OWN_DATA);
      if (grant_data) begin
        owner_q <= OWN_DATA;
      end else if (grant_fetch) begin
        owner_q <= OWN_FETCH;
      end else if (finish) begin
        owner_q <= OWN_NONE; // released together with the done pulse
      end
    end
  end

  // request payload latched at grant
  always_ff @(posedge clk) begin
    if (grant_data) begin
      addr_q  <= data_addr_i;
      id_q    <= `MAB_ID_W'(`MAB_DATA_ID);
      wdata_q <= data_wdata_i;
      wstrb_q <= data_wstrb_i;
    end else if (grant_fetch) begin
      addr_q <= fetch_addr_i;
      id_q   <= `MAB_ID_W'(`MAB_FETCH_ID);
    end
  end

  // read data held for the owner, valid with its done
  always_ff @(posedge clk) begin
    if (rd_done_i && (owner_q == OWN_FETCH)) begin
      fetch_rdata_o <= rd_data_i;
    end
    if (rd_done_i && (owner_q == OWN_DATA)) begin
      data_rdata_o <= rd_data_i;
    end
  end

  assign rd_addr_o = addr_q;
  assign rd_id_o   = id_q;
  assign wr_addr_o = addr_q;
  assign wr_id_o   = id_q;
  assign wr_data_o = wdata_q;
  assign wr_strb_o = wstrb_q;

endmodule

/* logic/axi_read_master.sv */
`timescale 1ns/1ps
`include "mem_axi_bridge_config.svh"

module axi_read_master (
  input  logic                   clk,
  input  logic                   arst_n_i,
  // from the arbiter
  input  logic                   rd_start_i,
  input  logic [`MAB_ADDR_W-1:0] rd_addr_i,
  input  logic [`MAB_ID_W-1:0]   rd_id_i,
  output logic [`MAB_DATA_W-1:0] rd_data_o,
  output logic                   rd_done_o,
  // AR channel
  input  logic                   arready_i,
  output logic                   arvalid_o,
  output logic [`MAB_ADDR_W-1:0] araddr_o,
  output logic [`MAB_ID_W-1:0]   arid_o,
  output logic [7:0]             arlen_o,
  output logic [2:0]             arsize_o,
  output logic [1:0]             arburst_o,
  // R channel
  input  logic                   rvalid_i,
  input  logic [`MAB_DATA_W-1:0] rdata_i,
  output logic                   rready_o
);

  import mem_axi_pkg::*;

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_ADDR = 2'd1;
  localparam logic [1:0] ST_DATA = 2'd2;

  logic [1:0]             state_q;
  logic [`MAB_ADDR_W-1:0] addr_q;
  logic [`MAB_ID_W-1:0]   id_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= ST_IDLE;
      rd_done_o <= 1'b0;
    end else begin
      rd_done_o <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (rd_start_i) begin
            state_q <= ST_ADDR;
          end
        end
        ST_ADDR: begin
          if (arready_i) begin
            state_q <= ST_DATA; // address taken, wait for the beat
          end
        end
        ST_DATA: begin
          if (rvalid_i) begin
            state_q   <= ST_IDLE;
            rd_done_o <= 1'b1;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rd_start_i && (state_q == ST_IDLE)) begin
      addr_q <= rd_addr_i;
      id_q   <= rd_id_i;
    end
    if (rvalid_i && rready_o) begin
      rd_data_o <= rdata_i; // single beat, rlast not needed
    end
  end

  assign arvalid_o = (state_q == ST_ADDR);
  assign rready_o  = (state_q == ST_DATA);
  assign araddr_o  = addr_q;
  assign arid_o    = id_q;
  assign arlen_o   = AXI_LEN_SINGLE;
  assign arsize_o  = AXI_SIZE_WORD;
  assign arburst_o = AXI_BURST_INCR;

endmodule

/* logic/axi_write_master.sv */
`timescale 1ns/1ps
`include "mem_axi_bridge_config.svh"

module axi_write_master (
  input  logic                   clk,
  input  logic                   arst_n_i,
  // from the arbiter
  input  logic                   wr_start_i,
  input  logic [`MAB_ADDR_W-1:0] wr_addr_i,
  input  logic [`MAB_DATA_W-1:0] wr_data_i,
  input  logic [`MAB_STRB_W-1:0] wr_strb_i,
  input  logic [`MAB_ID_W-1:0]   wr_id_i,
  output logic                   wr_done_o,
  // AW channel
  input  logic                   awready_i,
  output logic                   awvalid_o,
  output logic [`MAB_ADDR_W-1:0] awaddr_o,
  output logic [`MAB_ID_W-1:0]   awid_o,
  output logic [7:0]             awlen_o,
  output logic [2:0]             awsize_o,
  output logic [1:0]             awburst_o,
  // W channel
  input  logic                   wready_i,
  output logic                   wvalid_o,
  output logic [`MAB_DATA_W-1:0] wdata_o,
  output logic [`MAB_STRB_W-1:0] wstrb_o,
  output logic                   wlast_o,
  // B channel
  input  logic                   bvalid_i,
  output logic                   bready_o
);

  import mem_axi_pkg::*;

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_SEND = 2'd1;
  localparam logic [1:0] ST_RESP = 2'd2;

  logic [1:0]             state_q;
  logic                   aw_ok_q;   // AW accepted
  logic                   w_ok_q;    // W accepted
  logic                   aw_hs;
  logic                   w_hs;
  logic                   both_done;
  logic [`MAB_ADDR_W-1:0] addr_q;
  logic [`MAB_ID_W-1:0]   id_q;
  logic [`MAB_DATA_W-1:0] data_q;
  logic [`MAB_STRB_W-1:0] strb_q;

  assign aw_hs     = awvalid_o && awready_i;
  assign w_hs      = wvalid_o && wready_i;
  // either channel may finish first
  assign both_done = (aw_ok_q || aw_hs) && (w_ok_q || w_hs);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= ST_IDLE;
      aw_ok_q   <= 1'b0;
      w_ok_q    <= 1'b0;
      wr_done_o <= 1'b0;
    end else begin
      wr_done_o <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (wr_start_i) begin
            state_q <= ST_SEND;
          end
        end
        ST_SEND: begin
          if (both_done) begin
            state_q <= ST_RESP;
            aw_ok_q <= 1'b0;
            w_ok_q  <= 1'b0;
          end else begin
            aw_ok_q <= aw_ok_q || aw_hs;
            w_ok_q  <= w_ok_q || w_hs;
          end
        end
        ST_RESP: begin
          if (bvalid_i) begin
            state_q   <= ST_IDLE;
            wr_done_o <= 1'b1; // bresp ignored
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_start_i && (state_q == ST_IDLE)) begin
      addr_q <= wr_addr_i;
      id_q   <= wr_id_i;
      data_q <= wr_data_i;
      strb_q <= wr_strb_i;
    end
  end

  assign awvalid_o = (state_q == ST_SEND) && !aw_ok_q;
  assign wvalid_o  = (state_q == ST_SEND) && !w_ok_q;
  assign bready_o  = (state_q == ST_RESP);
  assign awaddr_o  = addr_q;
  assign awid_o    = id_q;
  assign awlen_o   = AXI_LEN_SINGLE;
  assign awsize_o  = AXI_SIZE_WORD;
  assign awburst_o = AXI_BURST_INCR;
  assign wdata_o   = data_q;
  assign wstrb_o   = strb_q;
  assign wlast_o   = 1'b1; // every beat is the last one

endmodule

/* logic/mem_axi_bridge.sv */
`timescale 1ns/1ps
`include "mem_axi_bridge_config.svh"

module mem_axi_bridge (
  input  logic                   clk,
  input  logic                   arst_n_i,
  // fetch requester
  input  logic                   fetch_req_i,
  input  logic [`MAB_ADDR_W-1:0] fetch_addr_i,
  output logic [`MAB_DATA_W-1:0] fetch_rdata_o,
  output logic                   fetch_done_o,
  // load/store requester
  input  logic                   data_req_i,
  input  logic                   data_we_i,
  input  logic [`MAB_ADDR_W-1:0] data_addr_i,
  input  logic [`MAB_DATA_W-1:0] data_wdata_i,
  input  logic [`MAB_STRB_W-1:0] data_wstrb_i,
  output logic [`MAB_DATA_W-1:0] data_rdata_o,
  output logic                   data_done_o,
  // write address
  input  logic                   awready_i,
  output logic                   awvalid_o,
  output logic [`MAB_ADDR_W-1:0] awaddr_o,
  output logic [`MAB_ID_W-1:0]   awid_o,
  output logic [7:0]             awlen_o,
  output logic [2:0]             awsize_o,
  output logic [1:0]             awburst_o,
  // write data
  input  logic                   wready_i,
  output logic                   wvalid_o,
  output logic [`MAB_DATA_W-1:0] wdata_o,
  output logic [`MAB_STRB_W-1:0] wstrb_o,
  output logic                   wlast_o,
  // write response, resp and id not checked
  input  logic                   bvalid_i,
  output logic                   bready_o,
  input  logic [1:0]             bresp_i,
  input  logic [`MAB_ID_W-1:0]   bid_i,
  // read address
  input  logic                   arready_i,
  output logic                   arvalid_o,
  output logic [`MAB_ADDR_W-1:0] araddr_o,
  output logic [`MAB_ID_W-1:0]   arid_o,
  output logic [7:0]             arlen_o,
  output logic [2:0]             arsize_o,
  output logic [1:0]             arburst_o,
  // read data, resp, last and id not checked
  input  logic                   rvalid_i,
  input  logic [`MAB_DATA_W-1:0] rdata_i,
  output logic                   rready_o,
  input  logic [1:0]             rresp_i,
  input  logic                   rlast_i,
  input  logic [`MAB_ID_W-1:0]   rid_i
);

  logic                   rd_start;
  logic [`MAB_ADDR_W-1:0] rd_addr;
  logic [`MAB_ID_W-1:0]   rd_id;
  logic [`MAB_DATA_W-1:0] rd_data;
  logic                   rd_done;
  logic                   wr_start;
  logic [`MAB_ADDR_W-1:0] wr_addr;
  logic [`MAB_DATA_W-1:0] wr_data;
  logic [`MAB_STRB_W-1:0] wr_strb;
  logic [`MAB_ID_W-1:0]   wr_id;
  logic                   wr_done;

  // requester ports connect by name
  mem_axi_arbiter u_arbiter (
    .rd_start_o (rd_start),
    .rd_addr_o  (rd_addr),
    .rd_id_o    (rd_id),
    .rd_data_i  (rd_data),
    .rd_done_i  (rd_done),
    .wr_start_o (wr_start),
    .wr_addr_o  (wr_addr),
    .wr_data_o  (wr_data),
    .wr_strb_o  (wr_strb),
    .wr_id_o    (wr_id),
    .wr_done_i  (wr_done),
    .*
  );

  axi_read_master u_read_master (
    .rd_start_i (rd_start),
    .rd_addr_i  (rd_addr),
    .rd_id_i    (rd_id),
    .rd_data_o  (rd_data),
    .rd_done_o  (rd_done),
    .*
  );

  axi_write_master u_write_master (
    .wr_start_i (wr_start),
    .wr_addr_i  (wr_addr),
    .wr_data_i  (wr_data),
    .wr_strb_i  (wr_strb),
    .wr_id_i    (wr_id),
    .wr_done_o  (wr_done),
    .*
  );

endmodule

/* verif/mem_axi_bridge_sva.sv */
`timescale 1ns/1ps
`include "mem_axi_bridge_config.svh"

module mem_axi_bridge_sva (
  input logic                   clk,
  input logic                   arst_n_i,
  input logic                   arvalid_o,
  input logic                   arready_i,
  input logic [`MAB_ADDR_W-1:0] araddr_o,
  input logic [`MAB_ID_W-1:0]   arid_o,
  input logic                   awvalid_o,
  input logic                   awready_i,
  input logic [`MAB_ADDR_W-1:0] awaddr_o,
  input logic                   wvalid_o,
  input logic                   wready_i,
  input logic [`MAB_DATA_W-1:0] wdata_o,
  input logic [`MAB_STRB_W-1:0] wstrb_o,
  input logic                   fetch_done_o,
  input logic                   data_done_o
);

  ar_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
    arvalid_o && !arready_i |=> arvalid_o && $stable(araddr_o) && $stable(arid_o))
    else $error("AR valid or payload changed before arready");

  aw_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
    awvalid_o && !awready_i |=> awvalid_o && $stable(awaddr_o))
    else $error("AW valid or payload changed before awready");

  w_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
    wvalid_o && !wready_i |=> wvalid_o && $stable(wdata_o) && $stable(wstrb_o))
    else $error("W valid or payload changed before wready");

  // done lasts one cycle only
  done_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
    (fetch_done_o || data_done_o) |=> !(fetch_done_o || data_done_o))
    else $error("done held longer than one cycle");

  one_in_flight: assert property (@(posedge clk) disable iff (!arst_n_i)
    !(arvalid_o && awvalid_o))
    else $error("read and write address pending together");

endmodule

bind mem_axi_bridge mem_axi_bridge_sva u_sva (.*);

/* verif/mem_axi_bridge_tb.sv */
`timescale 1ns/1ps
`include "mem_axi_bridge_config.svh"

module mem_axi_bridge_tb;

  localparam int N_ENTRIES  = 9;
  localparam int KIND_FETCH = 0;
  localparam int KIND_DATA  = 1;
  localparam int KIND_BOTH  = 2;

  logic clk, arst_n_i, fetch_req_i, fetch_done_o, data_req_i, data_we_i, data_done_o;
  logic awready_i, awvalid_o, wready_i, wvalid_o, wlast_o, bvalid_i, bready_o;
  logic arready_i, arvalid_o, rvalid_i, rready_o, rlast_i;
  logic [`MAB_ADDR_W-1:0] fetch_addr_i, data_addr_i, awaddr_o, araddr_o;
  logic [`MAB_DATA_W-1:0] fetch_rdata_o, data_wdata_i, data_rdata_o, wdata_o, rdata_i;
  logic [`MAB_STRB_W-1:0] data_wstrb_i, wstrb_o;
  logic [`MAB_ID_W-1:0]   awid_o, bid_i, arid_o, rid_i;
  logic [7:0]             awlen_o, arlen_o;
  logic [2:0]             awsize_o, arsize_o;
  logic [1:0]             awburst_o, arburst_o, bresp_i, rresp_i;

  // stimulus table, one entry per request set
  int                     tab_kind  [N_ENTRIES];
  logic                   tab_we    [N_ENTRIES];
  logic [`MAB_ADDR_W-1:0] tab_faddr [N_ENTRIES];
  logic [`MAB_ADDR_W-1:0] tab_daddr [N_ENTRIES];
  logic [`MAB_DATA_W-1:0] tab_wdata [N_ENTRIES];
  logic [`MAB_STRB_W-1:0] tab_strb  [N_ENTRIES];
  logic [`MAB_DATA_W-1:0] tab_fexp  [N_ENTRIES];
  logic [`MAB_DATA_W-1:0] tab_dexp  [N_ENTRIES];
  int                     n_tab;

  logic [`MAB_DATA_W-1:0] slave_mem [64];
  logic [`MAB_DATA_W-1:0] ref_mem   [64];
  logic [`MAB_ID_W-1:0]   exp_id_q [$];   // address phases in issue order
  logic [`MAB_ADDR_W-1:0] exp_addr_q [$];
  logic [`MAB_DATA_W-1:0] exp_wdata;
  logic [`MAB_STRB_W-1:0] exp_strb;
  logic [`MAB_ADDR_W-1:0] w_addr;
  logic [`MAB_DATA_W-1:0] w_data;
  logic [`MAB_STRB_W-1:0] w_strb;
  logic                   aw_got;
  logic                   w_got;

  mem_axi_bridge dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic stop_run();
    $display("Test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_rdata(input logic [`MAB_DATA_W-1:0] got, exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_axi_field(input logic [`MAB_ADDR_W-1:0] got, exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  // word value depends on its full byte address
  function automatic logic [`MAB_DATA_W-1:0] fill_word(input int idx);
    return 32'h1000_0000 | 32'(idx * 4);
  endfunction

  function automatic logic [`MAB_DATA_W-1:0] merge_bytes(input logic [`MAB_DATA_W-1:0] old_w,
      new_w, input logic [`MAB_STRB_W-1:0] strb);
    logic [`MAB_DATA_W-1:0] res;
    res = old_w;
    for (int b = 0; b < `MAB_STRB_W; b++) begin
      if (strb[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  task automatic add_entry(input int kind, input logic we, input logic [31:0] faddr, daddr,
      wdata, input logic [3:0] strb, input logic [31:0] fexp, dexp);
    tab_kind[n_tab]  = kind;
    tab_we[n_tab]    = we;
    tab_faddr[n_tab] = faddr;
    tab_daddr[n_tab] = daddr;
    tab_wdata[n_tab] = wdata;
    tab_strb[n_tab]  = strb;
    tab_fexp[n_tab]  = fexp;
    tab_dexp[n_tab]  = dexp;
    n_tab++;
  endtask

  // common AR/AW field checks against the next expected address phase
  task automatic check_addr_phase(input logic [`MAB_ID_W-1:0] id, input logic [31:0] addr,
      input logic [7:0] len, input logic [2:0] size, input logic [1:0] burst, input string ch);
    if (exp_id_q.size() == 0) begin
      $display("%s address phase seen with no request pending", ch);
      stop_run();
    end
    check_axi_field(`MAB_ADDR_W'(id), `MAB_ADDR_W'(exp_id_q.pop_front()), {ch, " id"});
    check_axi_field(addr, exp_addr_q.pop_front(), {ch, " addr"});
    check_axi_field(`MAB_ADDR_W'(len), 0, {ch, " len"});
    check_axi_field(`MAB_ADDR_W'(size), 2, {ch, " size"}); // 4 bytes per beat
    check_axi_field(`MAB_ADDR_W'(burst), 1, {ch, " burst"});
  endtask

  task automatic run_entry(input int idx);
    logic                   f_on;
    logic                   d_on;
    logic                   f_seen;
    logic                   d_seen;
    int                     cyc;
    int                     f_cyc;
    int                     d_cyc;
    logic [`MAB_DATA_W-1:0] ref_d;
    logic [`MAB_DATA_W-1:0] ref_f;
    f_on  = (tab_kind[idx] != KIND_DATA);
    d_on  = (tab_kind[idx] != KIND_FETCH);
    cyc   = 0;
    f_cyc = 0;
    d_cyc = 0;
    ref_d = ref_mem[tab_daddr[idx][7:2]];
    if (d_on) begin // data port goes first
      exp_id_q.push_back(`MAB_ID_W'(`MAB_DATA_ID));
      exp_addr_q.push_back(tab_daddr[idx]);
      if (tab_we[idx]) begin
        ref_mem[tab_daddr[idx][7:2]] = merge_bytes(ref_d, tab_wdata[idx], tab_strb[idx]);
        exp_wdata = tab_wdata[idx];
        exp_strb  = tab_strb[idx];
      end
    end
    ref_f = ref_mem[tab_faddr[idx][7:2]];
    if (f_on) begin
      exp_id_q.push_back(`MAB_ID_W'(`MAB_FETCH_ID));
      exp_addr_q.push_back(tab_faddr[idx]);
    end
    @(posedge clk);
    fetch_req_i  <= f_on;
    fetch_addr_i <= tab_faddr[idx];
    data_req_i   <= d_on;
    data_we_i    <= tab_we[idx];
    data_addr_i  <= tab_daddr[idx];
    data_wdata_i <= tab_wdata[idx];
    data_wstrb_i <= tab_strb[idx];
    f_seen = !f_on;
    d_seen = !d_on;
    while (!(f_seen && d_seen)) begin
      @(negedge clk);
      cyc++;
      if (fetch_done_o) begin
        if (f_seen) begin
          $display("fetch done pulse with no fetch request pending");
          stop_run();
        end
        check_rdata(fetch_rdata_o, tab_fexp[idx], "fetch rdata");
        check_rdata(fetch_rdata_o, ref_f, "fetch rdata vs reference");
        f_seen = 1'b1;
        f_cyc  = cyc;
      end
      if (data_done_o) begin
        if (d_seen) begin
          $display("data done pulse with no data request pending");
          stop_run();
        end
        if (!tab_we[idx]) begin
          check_rdata(data_rdata_o, tab_dexp[idx], "data rdata");
          check_rdata(data_rdata_o, ref_d, "data rdata vs reference");
        end
        d_seen = 1'b1;
        d_cyc  = cyc;
      end
      @(posedge clk);
      if (f_seen) fetch_req_i <= 1'b0;
      if (d_seen) data_req_i <= 1'b0;
    end
    if (f_on && d_on && d_cyc >= f_cyc) begin
      $display("data request did not finish before the fetch request");
      stop_run();
    end
  endtask

  initial begin : ar_slave
    logic [`MAB_ADDR_W-1:0] addr;
    forever begin
      @(negedge clk);
      if (arvalid_o) begin
        addr = araddr_o;
        check_addr_phase(arid_o, addr, arlen_o, arsize_o, arburst_o, "AR");
        repeat ($urandom_range(3, 0)) @(posedge clk);
        @(posedge clk);
        arready_i <= 1'b1;
        @(posedge clk);
        arready_i <= 1'b0;
        repeat ($urandom_range(3, 0)) @(posedge clk);
        rdata_i  <= slave_mem[addr[7:2]];
        rvalid_i <= 1'b1;
        do @(negedge clk); while (!rready_o); // beat held until the master takes it
        @(posedge clk);
        rvalid_i <= 1'b0;
      end
    end
  end

  initial begin : aw_slave
    forever begin
      @(negedge clk);
      if (awvalid_o) begin
        w_addr = awaddr_o;
        check_addr_phase(awid_o, w_addr, awlen_o, awsize_o, awburst_o, "AW");
        repeat ($urandom_range(3, 0)) @(posedge clk);
        @(posedge clk);
        awready_i <= 1'b1;
        @(posedge clk);
        awready_i <= 1'b0;
        aw_got = 1'b1;
      end
    end
  end

  initial begin : w_slave
    forever begin
      @(negedge clk);
      if (wvalid_o) begin
        w_data = wdata_o;
        w_strb = wstrb_o;
        check_axi_field(w_data, exp_wdata, "wdata");
        check_axi_field(`MAB_ADDR_W'(w_strb), `MAB_ADDR_W'(exp_strb), "wstrb");
        check_axi_field(`MAB_ADDR_W'(wlast_o), 1, "wlast");
        repeat ($urandom_range(3, 0)) @(posedge clk);
        @(posedge clk);
        wready_i <= 1'b1;
        @(posedge clk);
        wready_i <= 1'b0;
        w_got = 1'b1;
      end
    end
  end

  initial begin : b_slave
    forever begin
      @(negedge clk);
      if (aw_got && w_got) begin
        slave_mem[w_addr[7:2]] = merge_bytes(slave_mem[w_addr[7:2]], w_data, w_strb);
        aw_got = 1'b0;
        w_got  = 1'b0;
        repeat ($urandom_range(3, 0)) @(posedge clk);
        @(posedge clk);
        bvalid_i <= 1'b1;
        do @(negedge clk); while (!bready_o); // response held until bready
        @(posedge clk);
        bvalid_i <= 1'b0;
      end
    end
  end

  initial begin : watchdog
    repeat (N_ENTRIES * 40 + 8) @(posedge clk);
    $display("timeout, requests not finished within the cycle budget");
    $display("Test failed");
    $fatal(1, "watchdog expired");
  end

  initial begin : main
    void'($urandom(32'hd6e69c22));
    {arst_n_i, fetch_req_i, data_req_i, data_we_i} = '0;
    {fetch_addr_i, data_addr_i, data_wdata_i, data_wstrb_i} = '0;
    {awready_i, wready_i, bvalid_i, arready_i, rvalid_i, rdata_i} = '0;
    {bresp_i, rresp_i, rid_i} = '0;
    bid_i   = `MAB_ID_W'(`MAB_DATA_ID);
    rlast_i = 1'b1;
    aw_got  = 1'b0;
    w_got   = 1'b0;
    for (int i = 0; i < 64; i++) begin
      slave_mem[i] = fill_word(i);
      ref_mem[i]   = fill_word(i);
    end
    n_tab = 0;
    add_entry(KIND_FETCH, 0, 32'h10, 32'h00, 32'h0,         4'h0, 32'h1000_0010, 32'h0);
    add_entry(KIND_DATA,  1, 32'h00, 32'h20, 32'hdeadbeef, 4'hf, 32'h0, 32'h0);
    add_entry(KIND_DATA,  0, 32'h00, 32'h20, 32'h0,         4'h0, 32'h0, 32'hdeadbeef);
    add_entry(KIND_DATA,  1, 32'h00, 32'h24, 32'h11223344, 4'h5, 32'h0, 32'h0);
    add_entry(KIND_DATA,  0, 32'h00, 32'h24, 32'h0,         4'h0, 32'h0, 32'h1022_0044);
    add_entry(KIND_BOTH,  1, 32'h30, 32'h34, 32'ha5a5a5a5, 4'hc, 32'h1000_0030, 32'h0);
    add_entry(KIND_BOTH,  0, 32'h20, 32'h34, 32'h0,         4'h0, 32'hdeadbeef, 32'ha5a5_0034);
    add_entry(KIND_DATA,  1, 32'h00, 32'hfc, 32'h0000ab00, 4'h2, 32'h0, 32'h0);
    add_entry(KIND_FETCH, 0, 32'hfc, 32'h00, 32'h0,         4'h0, 32'h1000_abfc, 32'h0);
    repeat (8) @(posedge clk);
    arst_n_i <= 1'b1;
    @(negedge clk);
    check_axi_field(`MAB_ADDR_W'({arvalid_o, awvalid_o, wvalid_o, rready_o, bready_o,
                    fetch_done_o, data_done_o}), '0, "valid/ready/done after reset");
    for (int i = 0; i < n_tab; i++) begin
      run_entry(i);
    end
    if (exp_id_q.size() != 0) begin
      $display("expected address phase never appeared on the bus");
      $display("Test failed");
      $fatal(1, "missing transaction");
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

/* mem_axi_bridge.f */
+incdir+logic
logic/mem_axi_pkg.sv
logic/mem_axi_arbiter.sv
logic/axi_read_master.sv
logic/axi_write_master.sv
logic/mem_axi_bridge.sv
verif/mem_axi_bridge_sva.sv
verif/mem_axi_bridge_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := mem_axi_bridge_tb
FILELIST  := mem_axi_bridge.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
